//--- fifo_params.svh
/*
 * stream buffer sizing
 * word width, depth of the RAM-backed FIFO and the RAM address width,
 * shared by the packages and the RAM side of the design
 */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// bits in one buffered word, tag included
`define FIFO_WIDTH 32

// width of the sequence tag at the top of each word
`define FIFO_SEQ_W 4

// entries held by the big FIFO, and the address bits needed to reach them
`define FIFO_ELS 16
`define FIFO_ADDR_W 4

`endif

//--- stream_pkg.sv
/*
 * stream word types
 * the word carried from input to output through every stage of the buffer,
 * with a small sequence tag ahead of the payload
 */
`include "fifo_params.svh"

package stream_pkg;

   // the tag is only there to make mismatches easy to read in simulation
   // and the datapath never looks inside the word
   typedef struct packed
   {
      logic [`FIFO_SEQ_W-1:0]             seq;
      logic [`FIFO_WIDTH-`FIFO_SEQ_W-1:0] payload;
   } stream_word_t;

   // all-zero word, handy for idle buses
   localparam stream_word_t stream_word_zero = '0;

endpackage

//--- ram_pkg.sv
/*
 * single-port RAM access types
 * one request per cycle, either a write of a stream word or a read
 * whose data comes back on the following cycle
 */
`include "fifo_params.svh"

package ram_pkg;

   import stream_pkg::*;

   // we selects write when high and read when low, and data is ignored on reads
   typedef struct packed
   {
      logic                    v;
      logic                    we;
      logic [`FIFO_ADDR_W-1:0] addr;
      stream_word_t            data;
   } ram_req_t;

endpackage

//--- sram_1rw.sv
/*
 * single-port synchronous RAM
 * one access per cycle, a write or a read; read data is registered
 * and appears exactly one cycle after the read request
 */
`timescale 1ns/10ps
`include "fifo_params.svh"

module sram_1rw
   import stream_pkg::*;
   import ram_pkg::*;
(
   input  logic         clk_i,
   input  ram_req_t     req_i,
   output stream_word_t rdata_o
);

   // storage array, its contents are only read after being written
   stream_word_t mem [`FIFO_ELS];

   stream_word_t rdata_r;

   // a single port means a write and a read never share a cycle
   always_ff @(posedge clk_i)
   begin
      if (req_i.v)
      begin
         if (req_i.we)
         begin
            mem[req_i.addr] <= req_i.data;
         end
         else
         begin
            // read data holds until the next read, writes leave it alone
            rdata_r <= mem[req_i.addr];
         end
      end
   end

   assign rdata_o = rdata_r;

endmodule

//--- fifo_1rw_big.sv
/*
 * RAM-backed FIFO on a single-port memory
 * each cycle it either enqueues or dequeues, never both; read and write
 * pointers with a wrap bit track full and empty, and the dequeued word
 * shows on data_o one cycle after the dequeue
 */
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_1rw_big
   import stream_pkg::*;
   import ram_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   input  logic         v_i,
   input  logic         enq_not_deq_i,
   input  stream_word_t data_i,
   output logic         full_o,
   output logic         empty_o,
   output stream_word_t data_o
);

   // address of the last RAM entry, where pointers wrap back to zero
   localparam logic [`FIFO_ADDR_W-1:0] last_addr = `FIFO_ADDR_W'(`FIFO_ELS - 1);

   // pointers carry the wrap bit in the top position
   logic [`FIFO_ADDR_W:0] rd_ptr_r;
   logic [`FIFO_ADDR_W:0] wr_ptr_r;
   logic [`FIFO_ADDR_W:0] rd_ptr_n;
   logic [`FIFO_ADDR_W:0] wr_ptr_n;

   logic full_r;
   logic empty_r;
   logic enq;
   logic deq;

   ram_req_t ram_req;

   // step a pointer by one entry, flipping the wrap bit past the last entry
   function automatic logic [`FIFO_ADDR_W:0] ptr_advance(input logic [`FIFO_ADDR_W:0] ptr);
      logic [`FIFO_ADDR_W:0] nxt;
      if (ptr[`FIFO_ADDR_W-1:0] == last_addr)
      begin
         nxt = {~ptr[`FIFO_ADDR_W], {`FIFO_ADDR_W{1'b0}}};
      end
      else
      begin
         nxt = {ptr[`FIFO_ADDR_W], ptr[`FIFO_ADDR_W-1:0] + 1'b1};
      end
      return nxt;
   endfunction

   // the steering logic should never push when full or pop when empty,
   // but the flags guard the pointers all the same
   assign enq = v_i & enq_not_deq_i & ~full_r;
   assign deq = v_i & ~enq_not_deq_i & ~empty_r;

   always_comb
   begin
      wr_ptr_n = enq ? ptr_advance(wr_ptr_r) : wr_ptr_r;
      rd_ptr_n = deq ? ptr_advance(rd_ptr_r) : rd_ptr_r;
   end

   // flags come from the next pointers so they are valid the cycle after an access
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         full_r   <= 1'b0;
         empty_r  <= 1'b1;
      end
      else
      begin
         rd_ptr_r <= rd_ptr_n;
         wr_ptr_r <= wr_ptr_n;
         // same entry on different laps means every slot is occupied
         full_r   <= (rd_ptr_n[`FIFO_ADDR_W-1:0] == wr_ptr_n[`FIFO_ADDR_W-1:0])
                   & (rd_ptr_n[`FIFO_ADDR_W] != wr_ptr_n[`FIFO_ADDR_W]);
         empty_r  <= (rd_ptr_n == wr_ptr_n);
      end
   end

   // one request per cycle, the write pointer addresses enqueues and the
   // read pointer addresses dequeues
   always_comb
   begin
      ram_req.v    = enq | deq;
      ram_req.we   = enq;
      ram_req.addr = enq ? wr_ptr_r[`FIFO_ADDR_W-1:0] : rd_ptr_r[`FIFO_ADDR_W-1:0];
      ram_req.data = data_i;
   end

   sram_1rw ram
   (
      .clk_i   (clk_i),
      .req_i   (ram_req),
      .rdata_o (data_o)
   );

   assign full_o  = full_r;
   assign empty_o = empty_r;

endmodule

//--- fifo_two_elem.sv
/*
 * two-entry register FIFO
 * small circular buffer with valid/yumi on the output side; while full it
 * takes a new word in the same cycle the consumer takes the oldest one
 */
`timescale 1ns/10ps

module fifo_two_elem
   import stream_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   input  logic         v_i,
   input  stream_word_t data_i,
   output logic         ready_o,
   output logic         v_o,
   output stream_word_t data_o,
   input  logic         yumi_i
);

   stream_word_t slots [2];

   logic head_r;
   logic tail_r;
   logic full_r;
   logic empty;
   logic enq;
   logic deq;

   // head and tail on the same slot is either empty or full, the flag decides
   assign empty = (head_r == tail_r) & ~full_r;

   // a yumi frees the head slot in time for a word arriving while full
   assign deq = yumi_i & ~empty;
   assign enq = v_i & (~full_r | deq);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         head_r <= 1'b0;
         tail_r <= 1'b0;
         full_r <= 1'b0;
      end
      else
      begin
         if (enq)
         begin
            tail_r <= ~tail_r;
         end
         if (deq)
         begin
            head_r <= ~head_r;
         end
         // occupancy only changes when exactly one side moves
         if (enq & ~deq)
         begin
            full_r <= (~tail_r == head_r);
         end
         else if (deq & ~enq)
         begin
            full_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         slots[tail_r] <= data_i;
      end
   end

   assign ready_o = ~full_r;
   assign v_o     = ~empty;
   assign data_o  = slots[head_r];

endmodule

//--- fifo_1r1w_pseudo_large.sv
/*
 * pseudo dual-port stream FIFO
 * looks like a one-read one-write FIFO but keeps most words in a RAM-backed
 * FIFO on a single-port memory; a two-entry register FIFO in front of the
 * output absorbs the cycles where the RAM is busy taking writes
 * words bypass the RAM while the small FIFO has room and are fetched back
 * from it in cycles without an incoming word
 */
`timescale 1ns/10ps

module fifo_1r1w_pseudo_large
   import stream_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   input  logic         v_i,
   input  stream_word_t data_i,
   output logic         ready_and_o,
   output logic         v_o,
   output stream_word_t data_o,
   input  logic         yumi_i
);

   logic         big_full;
   logic         big_empty;
   stream_word_t big_data;
   logic         big_enq;
   logic         big_deq;
   logic         big_deq_r;
   logic         big_v;

   logic         little_ready;
   logic         little_has_space;
   logic         little_v;
   stream_word_t little_data;

   // the consumer's yumi frees a slot in time for a word entering this cycle
   assign little_has_space = little_ready | yumi_i;

   // producer back-pressure only depends on the RAM side
   assign ready_and_o = ~big_full;

   // remembers that the RAM read data must be caught by the small FIFO now
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         big_deq_r <= 1'b0;
      end
      else
      begin
         big_deq_r <= big_deq;
      end
   end

   always_comb
   begin
      if (big_deq_r)
      begin
         // the fetched word arrives now and was reserved a slot when it was fetched
         little_v = 1'b1;
         // the fetch freed an entry, so the RAM can take the incoming word
         big_enq  = v_i;
         // chain another fetch only when the small FIFO is empty, which is
         // what keeps a second in-flight word from overrunning it
         big_deq  = ~big_empty & ~big_enq & ~v_o;
      end
      else if (big_empty)
      begin
         // nothing queued in the RAM, so order allows the bypass path
         little_v = v_i & little_has_space;
         big_enq  = v_i & ~little_has_space;
         big_deq  = 1'b0;
      end
      else
      begin
         // older words sit in the RAM, so new ones must queue behind them
         little_v = 1'b0;
         big_enq  = v_i & ~big_full;
         // the RAM port is free only when no word is arriving
         big_deq  = ~big_enq & little_has_space;
      end

      big_v = big_enq | big_deq;
   end

   // a word fetched last cycle takes priority over the bypass word
   assign little_data = big_deq_r ? big_data : data_i;

   fifo_1rw_big big
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .v_i           (big_v),
      .enq_not_deq_i (big_enq),
      .data_i        (data_i),
      .full_o        (big_full),
      .empty_o       (big_empty),
      .data_o        (big_data)
   );

   fifo_two_elem little
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (little_v),
      .data_i  (little_data),
      .ready_o (little_ready),
      .v_o     (v_o),
      .data_o  (data_o),
      .yumi_i  (yumi_i)
   );

endmodule

//--- tb_fifo_pseudo.sv
/*
 * testbench for the pseudo dual-port stream FIFO
 * replays the traffic cases of the case file against a queue model of every
 * accepted word, checking order, integrity and capacity at the output
 */
`timescale 1ns/10ps
`include "fifo_params.svh"

module tb_fifo_pseudo
   import stream_pkg::*;
();

   localparam int reset_cycles = 16;
   localparam int fill_limit   = 200;

   logic         clk_i;
   logic         reset_i;
   logic         v_i;
   stream_word_t data_i;
   logic         ready_and_o;
   logic         v_o;
   stream_word_t data_o;
   logic         yumi_i;
   logic         rd_en;

   // every word the DUT accepted and has not yet handed back, oldest first
   stream_word_t model [$];
   stream_word_t cur_word;
   logic [3:0]   seq_cnt;
   logic         took_in;
   logic         stuck;
   logic [8*128-1:0] text_line;
   integer       seed;
   int           fd;
   int           fields;
   int           errors;
   int           err_start;
   int           checked;
   int           tests;
   int           sent;
   int           outs;
   int           mode;
   int           words;
   int           burst;
   int           gap;
   int           rd_int;
   int           exp_min;
   int           exp_max;

   // the consumer only takes a word while one is offered
   assign yumi_i = rd_en & v_o;

   fifo_1r1w_pseudo_large DUT
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .v_i         (v_i),
      .data_i      (data_i),
      .ready_and_o (ready_and_o),
      .v_o         (v_o),
      .data_o      (data_o),
      .yumi_i      (yumi_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #50 clk_i = ~clk_i;
      end
   end

   function automatic string mode_name(input int m);
      string name;
      case (m)
         0: name = "reset state";
         1: name = "paced traffic";
         2: name = "overflow and drain";
         3: name = "burst then gap";
         4: name = "random pacing";
         default: name = "unknown mode";
      endcase
      return name;
   endfunction

   // next producer word, the tag counts up and the payload is random
   task automatic load_word();
      logic [31:0] rnd;
      rnd              = $random(seed);
      cur_word.seq     = seq_cnt;
      cur_word.payload = rnd[`FIFO_WIDTH-`FIFO_SEQ_W-1:0];
      seq_cnt          = seq_cnt + 4'd1;
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      reset_i <= 1'b1;
      v_i     <= 1'b0;
      rd_en   <= 1'b0;
      repeat (reset_cycles)
      begin
         @(posedge clk_i);
      end
      reset_i <= 1'b0;
      model.delete();
   endtask

   // drive at the rising edge, then judge at the falling edge the transfers
   // that the next rising edge will carry out
   task automatic cycle(input logic drive_v, input logic drive_rd);
      stream_word_t expected;
      @(posedge clk_i);
      v_i    <= drive_v;
      data_i <= cur_word;
      rd_en  <= drive_rd;
      @(negedge clk_i);
      took_in = v_i & ready_and_o;
      assert (!(v_o && model.size() == 0))
      else
      begin
         $display("output offers a word although none is outstanding");
         errors++;
      end
      if (yumi_i && model.size() != 0)
      begin
         expected = model.pop_front();
         checked++;
         outs++;
         assert (data_o == expected)
         else
         begin
            $display("ERR data_o: expected %h got %h", expected, data_o);
            errors++;
         end
      end
      if (took_in)
      begin
         model.push_back(data_i);
         sent++;
         load_word();
      end
   endtask

   task automatic check_reset();
      apply_reset();
      @(negedge clk_i);
      assert (v_o == 1'b0)
      else
      begin
         $display("ERR v_o: expected %h got %h", 1'b0, v_o);
         errors++;
      end
      assert (ready_and_o == 1'b1)
      else
      begin
         $display("ERR ready_and_o: expected %h got %h", 1'b1, ready_and_o);
         errors++;
      end
   endtask

   // paced or random traffic, running until every word went in and came out
   task automatic run_traffic(input logic rand_pace, input int n_words, input int n_burst,
                              input int n_gap, input int n_rd);
      logic [31:0] rnd;
      logic        drive_v;
      logic        drive_rd;
      int          burst_left;
      int          gap_left;
      int          cyc;
      int          limit;
      burst_left = n_burst;
      gap_left   = 0;
      cyc        = 0;
      limit      = n_words * 40 + 400;
      while ((sent < n_words || model.size() != 0) && cyc < limit)
      begin
         rnd = $random(seed);
         if (rand_pace)
         begin
            drive_v  = (sent < n_words) & rnd[0];
            drive_rd = rnd[1];
         end
         else
         begin
            drive_v  = (sent < n_words) && gap_left == 0;
            drive_rd = (cyc % n_rd) == 0;
         end
         cycle(drive_v, drive_rd);
         cyc++;
         // a burst ends after its last accepted word and then idles n_gap cycles
         if (gap_left > 0)
         begin
            gap_left--;
         end
         else if (took_in && n_burst > 0)
         begin
            burst_left--;
            if (burst_left == 0)
            begin
               burst_left = n_burst;
               gap_left   = n_gap;
            end
         end
      end
      assert (cyc < limit)
      else
      begin
         $display("timeout with %0d words still inside the buffer", model.size());
         errors++;
         stuck = 1'b1;
      end
      cycle(1'b0, 1'b0);
   endtask

   // with the consumer held off the buffer fills up until it pushes back
   task automatic run_overflow(input int lo, input int hi);
      int i;
      int cyc;
      for (i = 0; i < `FIFO_ELS; i++)
      begin
         cycle(1'b1, 1'b0);
         assert (took_in)
         else
         begin
            $display("word %0d was refused below the guaranteed capacity", i);
            errors++;
         end
      end
      cyc = 0;
      while (took_in && cyc < fill_limit)
      begin
         cycle(1'b1, 1'b0);
         cyc++;
      end
      assert (!took_in)
      else
      begin
         $display("ready_and_o never dropped while the consumer was held off");
         errors++;
         stuck = 1'b1;
      end
      assert (sent >= lo && sent <= hi)
      else
      begin
         $display("ERR accepted words: expected %h to %h got %h", lo, hi, sent);
         errors++;
      end
      cyc = 0;
      while (model.size() != 0 && cyc < fill_limit)
      begin
         cycle(1'b0, 1'b1);
         cyc++;
      end
      assert (model.size() == 0)
      else
      begin
         $display("drain timed out with %0d words left", model.size());
         errors++;
         stuck = 1'b1;
      end
      cycle(1'b0, 1'b0);
   endtask

   initial
   begin
      reset_i = 1'b1;
      v_i     = 1'b0;
      data_i  = stream_word_zero;
      rd_en   = 1'b0;
      took_in = 1'b0;
      stuck   = 1'b0;
      seed    = 32'h7d1a;
      seq_cnt = '0;
      errors  = 0;
      checked = 0;
      tests   = 0;
      load_word();
      apply_reset();
      fd = $fopen("fifo_pseudo_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the case file fifo_pseudo_cases.txt");
         errors++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            text_line = '0;
            void'($fgets(text_line, fd));
            // comment and blank lines match no field and are skipped
            fields = $sscanf(text_line, "%d %d %d %d %d %d %d",
                             mode, words, burst, gap, rd_int, exp_min, exp_max);
            if (fields == 7)
            begin
               tests++;
               err_start = errors;
               sent      = 0;
               outs      = 0;
               stuck     = 1'b0;
               case (mode)
                  0: check_reset();
                  2: run_overflow(exp_min, exp_max);
                  4: run_traffic(1'b1, words, 0, 0, 1);
                  default: run_traffic(1'b0, words, burst, gap, rd_int);
               endcase
               // the reset case moves no words, so only traffic cases count output
               if (mode != 0)
               begin
                  assert (outs >= exp_min && outs <= exp_max)
                  else
                  begin
                     $display("ERR words out: expected %h to %h got %h",
                              exp_min, exp_max, outs);
                     errors++;
                  end
               end
               if (stuck)
               begin
                  apply_reset();
               end
               $display("test %0d %s: %0d in, %0d out, %0d errors",
                        tests, mode_name(mode), sent, outs, errors - err_start);
            end
         end
         $fclose(fd);
      end
      $display("tests %0d, words checked %0d, errors %0d", tests, checked, errors);
      if (errors == 0 && tests > 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- fifo_pseudo_cases.txt
# columns: mode words burst gap read_interval min_out max_out
# mode 0 reset state, 1 paced, 2 overflow and drain, 3 burst then gap, 4 random pacing
0 0 0 0 1 0 0
1 64 1 1 2 64 64
1 40 1 0 1 40 40
2 0 0 0 1 16 19
3 32 4 4 2 32 32
3 48 8 8 2 48 48
3 60 20 20 2 60 60
3 36 12 14 2 36 36
4 300 0 0 1 300 300
0 0 0 0 1 0 0
2 0 0 0 1 16 19
1 30 2 2 3 30 30
4 200 0 0 1 200 200
3 34 17 17 2 34 34

//--- vlog.f
+incdir+.
stream_pkg.sv
ram_pkg.sv
sram_1rw.sv
fifo_1rw_big.sv
fifo_two_elem.sv
fifo_1r1w_pseudo_large.sv
tb_fifo_pseudo.sv

//--- Makefile
# Verilator build and run of the pseudo dual-port stream FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_fifo_pseudo
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/10ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) fifo_params.svh
CASES   := fifo_pseudo_cases.txt
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides the status, the run fails without the pass line
run: $(BIN) $(CASES)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
